//--- hw/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// data path width in bits
`define MEM_DATA_W 32

// byte address bits that index the memory array
`define MEM_ADDR_BITS 12

// request queue entries, also the sender's credits after reset
`define MEM_REQ_DEPTH 4

// load response credits granted after reset
`define MEM_RESP_CREDITS 2

`define MEM_TRIGGER_ADDR 32'h0000_0100

`endif

//--- hw/mem_pkg.sv
`include "mem_cfg.svh"

package mem_pkg;

    typedef logic [`MEM_DATA_W-1:0] word_t;
    typedef logic [31:0]            addr_t;
    typedef logic [7:0]             byte_t;
    typedef logic [2:0]             mem_mode_t;
    typedef logic [2:0]             credit_t;   // holds either credit count

    // access modes, shared by store lanes and load extension
    localparam mem_mode_t MODE_WORD   = 3'd1;
    localparam mem_mode_t MODE_HALF   = 3'd2;   // signed
    localparam mem_mode_t MODE_BYTE   = 3'd3;   // signed
    localparam mem_mode_t MODE_HALF_U = 3'd4;
    localparam mem_mode_t MODE_BYTE_U = 3'd5;

    typedef enum logic [1:0] {
        idle,
        access,
        respond
    } ctrl_state_e;

endpackage

//--- hw/mem_req_if.sv
interface mem_req_if;
    import mem_pkg::*;

    logic      valid;
    logic      we;
    mem_mode_t mode;
    addr_t     addr;
    word_t     wdata;

    modport src (
        output valid,
        output we,
        output mode,
        output addr,
        output wdata
    );

    modport dst (
        input valid,
        input we,
        input mode,
        input addr,
        input wdata
    );

endinterface

//--- hw/req_queue.sv
`include "mem_cfg.svh"

module req_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               valid,
    input  logic               we,
    input  mem_pkg::mem_mode_t mode,
    input  mem_pkg::addr_t     addr,
    input  mem_pkg::word_t     wdata,
    input  logic               pop,
    mem_req_if.src             head,
    output logic               credit
);
    import mem_pkg::*;

    localparam int DEPTH = `MEM_REQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic      q_we    [DEPTH];
    mem_mode_t q_mode  [DEPTH];
    addr_t     q_addr  [DEPTH];
    word_t     q_wdata [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1))
        begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (valid)
        begin
            q_we[wr_ptr]    <= we;
            q_mode[wr_ptr]  <= mode;
            q_addr[wr_ptr]  <= addr;
            q_wdata[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            if (valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= pop;          // one credit back per popped entry
        end
    end

    assign head.valid = (count != '0);
    assign head.we    = q_we[rd_ptr];
    assign head.mode  = q_mode[rd_ptr];
    assign head.addr  = q_addr[rd_ptr];
    assign head.wdata = q_wdata[rd_ptr];

endmodule

//--- hw/credit_counter.sv
`include "mem_cfg.svh"

module credit_counter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              grant,
    input  logic              take,
    output mem_pkg::credit_t  count,
    output logic              avail
);
    import mem_pkg::*;

    credit_t count_next;

    always_comb
    begin
        count_next = count;
        if (grant && !take)
            count_next = count + 1'b1;
        else if (take && !grant)
            count_next = count - 1'b1;     // grant with take cancels out
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= credit_t'(`MEM_RESP_CREDITS);
            avail <= (`MEM_RESP_CREDITS != 0);
        end
        else
        begin
            count <= count_next;
            avail <= (count_next != '0);    // tracks count, no extra decode downstream
        end
    end

endmodule

//--- hw/lsu_ctrl.sv
module lsu_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    mem_req_if.dst          head,
    output logic            pop,
    input  logic            credit_avail,
    output logic            spend,
    mem_req_if.src          mem,
    input  mem_pkg::word_t  rdata,
    output logic            resp_valid,
    output mem_pkg::word_t  resp_data
);
    import mem_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;

    logic      cur_we;
    mem_mode_t cur_mode;
    addr_t     cur_addr;
    word_t     cur_wdata;

    // a load without a response credit holds the whole queue
    assign pop   = (state == idle) && head.valid && (head.we || credit_avail);
    assign spend = (state == respond);

    always_comb
    begin
        state_next = state;
        case (state)
            idle:    if (pop) state_next = access;
            access:  state_next = cur_we ? idle : respond;
            respond: state_next = idle;
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= idle;
            resp_valid <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            resp_valid <= spend;            // single pulse per load
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            cur_we    <= head.we;
            cur_mode  <= head.mode;
            cur_addr  <= head.addr;
            cur_wdata <= head.wdata;
        end
        if (state == respond)
            resp_data <= rdata;
    end

    assign mem.valid = (state == access);
    assign mem.we    = cur_we;
    assign mem.mode  = cur_mode;
    assign mem.addr  = cur_addr;
    assign mem.wdata = cur_wdata;

endmodule

//--- hw/data_memory.sv
`include "mem_cfg.svh"

module data_memory (
    input  logic            clk,
    mem_req_if.dst          mem,
    input  logic            trigger,
    output mem_pkg::word_t  rdata
);
    import mem_pkg::*;

    localparam int AW    = `MEM_ADDR_BITS;
    localparam int CELLS = 1 << AW;

    typedef logic [AW-1:0] idx_t;

    byte_t ram [CELLS];

    idx_t  i0;
    idx_t  i1;
    idx_t  i2;
    idx_t  i3;
    logic  is_trigger;
    word_t load_val;

    // byte indices wrap at the top of the array
    assign i0 = mem.addr[AW-1:0];
    assign i1 = i0 + idx_t'(1);
    assign i2 = i0 + idx_t'(2);
    assign i3 = i0 + idx_t'(3);

    assign is_trigger = (mem.addr == addr_t'(`MEM_TRIGGER_ADDR));

    always_ff @(posedge clk)
    begin
        if (mem.valid && mem.we && !is_trigger)
        begin
            case (mem.mode)
                MODE_WORD:
                begin
                    ram[i0] <= mem.wdata[7:0];
                    ram[i1] <= mem.wdata[15:8];
                    ram[i2] <= mem.wdata[23:16];
                    ram[i3] <= mem.wdata[31:24];
                end
                MODE_HALF, MODE_HALF_U:
                begin
                    ram[i0] <= mem.wdata[7:0];
                    ram[i1] <= mem.wdata[15:8];
                end
                MODE_BYTE, MODE_BYTE_U:
                begin
                    ram[i0] <= mem.wdata[7:0];
                end
                default: ;                  // unlisted mode writes nothing
            endcase
        end
    end

    always_comb
    begin
        if (is_trigger)
        begin
            load_val = {{(`MEM_DATA_W-1){1'b0}}, trigger};
        end
        else
        begin
            case (mem.mode)
                MODE_WORD:   load_val = {ram[i3], ram[i2], ram[i1], ram[i0]};
                MODE_HALF:   load_val = {{16{ram[i1][7]}}, ram[i1], ram[i0]};
                MODE_BYTE:   load_val = {{24{ram[i0][7]}}, ram[i0]};
                MODE_HALF_U: load_val = {16'b0, ram[i1], ram[i0]};
                MODE_BYTE_U: load_val = {24'b0, ram[i0]};
                default:     load_val = '0;
            endcase
        end
    end

    // registered read port
    always_ff @(posedge clk)
    begin
        if (mem.valid && !mem.we)
            rdata <= load_val;
    end

endmodule

//--- hw/mem_subsys_top.sv
module mem_subsys_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  logic               req_we,
    input  mem_pkg::mem_mode_t req_mode,
    input  mem_pkg::addr_t     req_addr,
    input  mem_pkg::word_t     req_wdata,
    output logic               req_credit,
    output logic               resp_valid,
    output mem_pkg::word_t     resp_data,
    input  logic               resp_credit,
    input  logic               trigger
);
    import mem_pkg::*;

    mem_req_if head_if ();   // queue head to controller
    mem_req_if mem_if ();    // controller to memory

    logic    pop;
    logic    spend;
    logic    credit_avail;
    credit_t resp_credit_cnt;
    word_t   rdata;

    req_queue u_req_queue (
        .clk    (clk),
        .rst_n  (rst_n),
        .valid  (req_valid),
        .we     (req_we),
        .mode   (req_mode),
        .addr   (req_addr),
        .wdata  (req_wdata),
        .pop    (pop),
        .head   (head_if.src),
        .credit (req_credit)
    );

    credit_counter u_resp_credits (
        .clk   (clk),
        .rst_n (rst_n),
        .grant (resp_credit),
        .take  (spend),
        .count (resp_credit_cnt),
        .avail (credit_avail)
    );

    lsu_ctrl u_lsu_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .head         (head_if.dst),
        .pop          (pop),
        .credit_avail (credit_avail),
        .spend        (spend),
        .mem          (mem_if.src),
        .rdata        (rdata),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data)
    );

    data_memory u_data_memory (
        .clk     (clk),
        .mem     (mem_if.dst),
        .trigger (trigger),
        .rdata   (rdata)
    );

endmodule

//--- dv/mem_subsys_sva.sv
`include "mem_cfg.svh"

module mem_subsys_sva (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  req_valid,
    input logic                                  resp_valid,
    input logic [$clog2(`MEM_REQ_DEPTH + 1)-1:0] queue_count,
    input mem_pkg::credit_t                      resp_credit_cnt
);
    import mem_pkg::*;

    localparam int CNT_W = $clog2(`MEM_REQ_DEPTH + 1);
    localparam logic [CNT_W-1:0] DEPTH    = CNT_W'(`MEM_REQ_DEPTH);
    localparam credit_t          RESP_MAX = credit_t'(`MEM_RESP_CREDITS);

    resp_low_in_reset: assert property (@(posedge clk) !rst_n |-> !resp_valid)
        else $error("resp_valid high while in reset");

    resp_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid)
        else $error("resp_valid held longer than one cycle");

    queue_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        queue_count <= DEPTH)
        else $error("request queue count above its depth");

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> queue_count < DEPTH)
        else $error("request pushed into a full queue");

    resp_credits_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        resp_credit_cnt <= RESP_MAX)
        else $error("response credit count above its reset value");

endmodule

bind mem_subsys_top mem_subsys_sva u_sva (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid       (req_valid),
    .resp_valid      (resp_valid),
    .queue_count     (u_req_queue.count),
    .resp_credit_cnt (resp_credit_cnt)
);

//--- dv/mem_subsys_tb.sv
`include "mem_cfg.svh"

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int         MAX_CASES         = 64;
    localparam int         TIMEOUT           = 100;    // cycles per wait
    localparam int         HOLD_WINDOW       = 30;
    localparam logic [3:0] BACKPRESSURE_TEST = 4'd5;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    logic      req_we;
    mem_mode_t req_mode;
    addr_t     req_addr;
    word_t     req_wdata;
    logic      req_credit;
    logic      resp_valid;
    word_t     resp_data;
    logic      resp_credit;
    logic      trigger;

    // test, we, mode, addr, wdata, trigger, expected
    logic [111:0] cases_mem [MAX_CASES];

    word_t resp_q [$];
    word_t exp_q  [$];
    int    seed = 32'h512bf910;
    int    req_credits_held;
    int    credit_pulses;
    int    credits_owed;       // responses not yet credited back
    int    delay_left;
    bit    delay_armed;
    bit    hold_resp;
    bit    aborted;
    int    checks;
    int    errors;
    int    test_errors;
    int    tests_run;
    int    n_cases;
    int    next_case;

    mem_subsys_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_we      (req_we),
        .req_mode    (req_mode),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_credit (resp_credit),
        .trigger     (trigger)
    );

    always #20 clk = ~clk;

    // sample outputs at the falling edge, then drive
    task automatic tick();
        @(negedge clk);
        if (req_credit)
        begin
            req_credits_held++;
            credit_pulses++;
        end
        if (resp_valid)
        begin
            resp_q.push_back(resp_data);
            credits_owed++;
        end
        req_valid   = 1'b0;
        resp_credit = 1'b0;
        if (!hold_resp && credits_owed > 0)
        begin
            if (!delay_armed)
            begin
                delay_left  = $unsigned($random(seed)) % 4;
                delay_armed = 1'b1;
            end
            if (delay_left == 0)
            begin
                resp_credit = 1'b1;
                credits_owed--;
                delay_armed = 1'b0;
            end
            else
                delay_left--;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at time %0t: timed out waiting for %s", $time, what);
        errors++;
        test_errors++;
        aborted = 1'b1;
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            test_errors++;
            $display("FAILED at time %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_credit(input string name, input credit_t exp, input credit_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            test_errors++;
            $display("FAILED at time %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic send_request(input logic [111:0] rec);
        int waited = 0;
        while (req_credits_held == 0 && waited < TIMEOUT)
        begin
            tick();
            waited++;
        end
        if (req_credits_held == 0)
            report_timeout("a request credit");
        else
        begin
            req_valid = 1'b1;
            req_we    = rec[104];
            req_mode  = rec[102:100];
            req_addr  = rec[99:68];
            req_wdata = rec[67:36];
            trigger   = rec[32];    // held until the next request
            req_credits_held--;
            tick();
        end
    endtask

    task automatic wait_responses(input int n);
        int waited = 0;
        while (resp_q.size() < n && waited < TIMEOUT)
        begin
            tick();
            waited++;
        end
        if (resp_q.size() < n)
            report_timeout("a load response");
    endtask

    task automatic compare_responses(input int n);
        for (int k = 0; k < n; k++)
        begin
            if (exp_q.size() > 0 && resp_q.size() > 0)
                check_word("resp_data", exp_q.pop_front(), resp_q.pop_front());
        end
    endtask

    // all request and response credits back home
    task automatic drain(input int sent);
        int waited = 0;
        while ((credit_pulses < sent || credits_owed != 0) && waited < TIMEOUT)
        begin
            tick();
            waited++;
        end
        if (credit_pulses < sent || credits_owed != 0)
            report_timeout("all credits to return");
        else
            tick();
    endtask

    task automatic run_test(input int first, output int next);
        logic [3:0] tid;
        int         i;
        int         sent;
        tid           = cases_mem[first][111:108];
        i             = first;
        sent          = 0;
        test_errors   = 0;
        credit_pulses = 0;
        hold_resp     = (tid == BACKPRESSURE_TEST);
        while (i < n_cases && cases_mem[i][111:108] == tid && !aborted)
        begin
            send_request(cases_mem[i]);
            sent++;
            if (!cases_mem[i][104])
            begin
                exp_q.push_back(cases_mem[i][31:0]);
                if (!hold_resp)
                begin
                    wait_responses(1);
                    compare_responses(1);
                end
            end
            i++;
        end
        if (hold_resp && !aborted)
        begin
            repeat (HOLD_WINDOW) tick();      // loads beyond the credits stay queued
            check_credit("responses while credits held", credit_t'(`MEM_RESP_CREDITS),
                         credit_t'(resp_q.size()));
            compare_responses(resp_q.size());
            hold_resp = 1'b0;
            wait_responses(exp_q.size());
            compare_responses(exp_q.size());
        end
        if (!aborted)
            drain(sent);
        if (!aborted)
        begin
            check_word("req_credit pulses", word_t'(sent), word_t'(credit_pulses));
            check_credit("request credits held", credit_t'(`MEM_REQ_DEPTH),
                         credit_t'(req_credits_held));
            check_credit("response credit count", credit_t'(`MEM_RESP_CREDITS),
                         UUT.resp_credit_cnt);
        end
        if (resp_q.size() != 0 || exp_q.size() != 0)
        begin
            $display("ERROR at time %0t: %0d responses and %0d expected loads left over",
                     $time, resp_q.size(), exp_q.size());
            errors++;
            test_errors++;
            resp_q.delete();
            exp_q.delete();
        end
        tests_run++;
        $display("test %0d %s: %0d requests, %0d errors", tid,
                 (test_errors == 0) ? "ok" : "with errors", sent, test_errors);
        next = i;
    endtask

    initial
    begin
        clk              = 1'b0;
        rst_n            = 1'b0;
        req_valid        = 1'b0;
        req_we           = 1'b0;
        req_mode         = '0;
        req_addr         = '0;
        req_wdata        = '0;
        resp_credit      = 1'b0;
        trigger          = 1'b0;
        req_credits_held = `MEM_REQ_DEPTH;
        credit_pulses    = 0;
        credits_owed     = 0;
        delay_left       = 0;
        delay_armed      = 1'b0;
        hold_resp        = 1'b0;
        aborted          = 1'b0;
        checks           = 0;
        errors           = 0;
        test_errors      = 0;
        tests_run        = 0;
        for (int i = 0; i < MAX_CASES; i++)
            cases_mem[i] = {4'hf, 108'(i)};    // test field f marks the end
        $readmemh("dv/mem_cases.txt", cases_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && cases_mem[n_cases][111:108] != 4'hf)
            n_cases++;
        if (n_cases == 0)
        begin
            $display("ERROR: no cases were read from dv/mem_cases.txt");
            errors++;
        end
        repeat (10) tick();
        rst_n     = 1'b1;
        next_case = 0;
        while (next_case < n_cases && !aborted)
            run_test(next_case, next_case);
        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- files.f
+incdir+hw
hw/mem_pkg.sv
hw/mem_req_if.sv
hw/req_queue.sv
hw/credit_counter.sv
hw/lsu_ctrl.sv
hw/data_memory.sv
hw/mem_subsys_top.sv
dv/mem_subsys_sva.sv
dv/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the memory subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module mem_subsys_tb -o mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mem_subsys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

//--- dv/mem_cases.txt
// test_we_mode_addr_wdata_trigger_expected, one access per line
// we=1 store (expected unused), we=0 load, test 5 runs with response credits held
1_1_1_00000000_11223344_0_00000000
1_1_1_00000004_a5a5f00f_0_00000000
1_1_1_000007fc_89abcdef_0_00000000
1_0_1_00000000_00000000_0_11223344
1_0_1_00000004_00000000_0_a5a5f00f
1_0_1_000007fc_00000000_0_89abcdef
2_1_1_00000010_11223344_0_00000000
2_1_2_00000012_00008765_0_00000000
2_1_3_00000011_ffffffaa_0_00000000
2_0_1_00000010_00000000_0_8765aa44
2_0_2_00000012_00000000_0_ffff8765
2_0_4_00000012_00000000_0_00008765
2_0_3_00000011_00000000_0_ffffffaa
2_0_5_00000011_00000000_0_000000aa
3_0_1_00000100_00000000_1_00000001
3_1_1_00000100_ffffffff_1_00000000
3_0_1_00000100_00000000_0_00000000
3_0_1_00000100_00000000_1_00000001
4_1_1_00000020_cafef00d_0_00000000
4_1_0_00000020_12345678_0_00000000
4_1_7_00000022_12345678_0_00000000
4_0_1_00000020_00000000_0_cafef00d
4_0_6_00000020_00000000_0_00000000
5_0_1_00000000_00000000_0_11223344
5_0_1_000007fc_00000000_0_89abcdef
5_0_1_00000010_00000000_0_8765aa44
5_0_1_00000020_00000000_0_cafef00d
5_0_5_00000004_00000000_0_0000000f
